/* bridge_settings.svh */
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// bus widths, fixed for the 32-bit data path
`define BRIDGE_AW     32              // haddr and axaddr width
`define BRIDGE_DW     32              // hwdata, hrdata, wdata and rdata width
`define BRIDGE_NSTRB  (`BRIDGE_DW/8)  // one write strobe per byte lane

// values the bus outputs take while rst_n is low
`define BRIDGE_HREADY_RST  1'b1       // slave ready
`define BRIDGE_HRESP_RST   1'b0       // OKAY response
`define BRIDGE_VALID_RST   1'b0       // no AXI request outstanding

`endif

/* ahb_pkg.sv */
`include "bridge_settings.svh"

package ahb_pkg;

   typedef enum logic [1:0] {
      IDLE   = 2'b00,   // no transfer
      BUSY   = 2'b01,   // master inserts a wait inside a burst
      NONSEQ = 2'b10,   // single or first transfer
      SEQ    = 2'b11    // following transfer of a burst
   } htrans_t;

   typedef enum logic [2:0] {
      BYTE = 3'b000,
      HALF = 3'b001,
      WORD = 3'b010
   } hsize_t;

   // tracks which AHB data phase is open
   typedef enum logic [1:0] {
      ST_IDLE = 2'b00,  // no data phase
      ST_WR   = 2'b01,  // write data phase
      ST_RD   = 2'b10,  // read data phase, command not yet loaded
      ST_PEND = 2'b11   // read issued, waiting on rvalid
   } bridge_state_t;

   typedef logic [`BRIDGE_AW-1:0] haddr_t;
   typedef logic [`BRIDGE_DW-1:0] hdata_t;

endpackage

/* axi_pkg.sv */
`include "bridge_settings.svh"

package axi_pkg;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,   // exclusive access ok
      SLVERR = 2'b10,   // slave error
      DECERR = 2'b11    // decode error, no slave at address
   } axi_resp_t;

   // bytes per beat as log2, same coding as hsize
   typedef logic [2:0] axi_size_t;

   typedef logic [`BRIDGE_NSTRB-1:0] axi_strb_t;

endpackage

/* bridge_cmd_if.sv */
`timescale 1ns/1ps

interface bridge_cmd_if;
   import ahb_pkg::*;
   import axi_pkg::*;

   logic      load;          // one-cycle load strobe
   logic      write;         // direction, 1 for write
   haddr_t    addr;
   hsize_t    size;
   hdata_t    wdata;         // taken straight from the AHB data phase
   axi_strb_t strb;
   logic      full;          // entry held and not completing this cycle
   logic      issued_write;  // direction of the held entry

   // AHB controller side
   modport ctrl (
      output load,
      output write,
      output addr,
      output size,
      output wdata,
      output strb,
      input  full,
      input  issued_write
   );

   // command buffer side
   modport buffer (
      input  load,
      input  write,
      input  addr,
      input  size,
      input  wdata,
      input  strb,
      output full,
      output issued_write
   );

endinterface

/* ahb_slave_ctrl.sv */
`timescale 1ns/1ps

`include "bridge_settings.svh"

module ahb_slave_ctrl (
   input  logic               ahb_clk,
   input  logic               rst_n,
   input  logic               hsel,
   input  ahb_pkg::haddr_t    haddr,
   input  ahb_pkg::htrans_t   htrans,
   input  ahb_pkg::hsize_t    hsize,
   input  logic               hwrite,
   input  ahb_pkg::hdata_t    hwdata,
   input  logic               hreadyin,
   input  logic               rvalid,
   input  ahb_pkg::hdata_t    rdata,
   input  axi_pkg::axi_resp_t rresp,
   output ahb_pkg::hdata_t    hrdata,
   output logic               hreadyout,
   output logic               hresp,
   bridge_cmd_if.ctrl         cmd
);
   import ahb_pkg::*;
   import axi_pkg::*;

   bridge_state_t state;
   bridge_state_t state_nxt;
   logic          state_en;

   logic          hready;      // transfer boundary seen by every slave
   logic          accept;      // address phase taken this cycle
   logic          load_en;

   haddr_t        haddr_q;
   hsize_t        hsize_q;
   logic          hwrite_q;

   logic          hresp_q;
   logic          hready_q;
   logic          misaligned;
   axi_strb_t     strb;

   hdata_t        rdata_q;
   logic          rdata_en;
   logic          rd_err_in;
   logic          rd_err_q;

   assign hready = hreadyout & hreadyin;
   assign accept = hsel & hready & ((htrans == NONSEQ) | (htrans == SEQ));

   // address phase fields, held for the whole data phase
   always_ff @(posedge ahb_clk) begin
      if (accept) begin
         haddr_q  <= haddr;
         hsize_q  <= hsize;
         hwrite_q <= hwrite;
      end
   end

   always_comb begin
      state_nxt = ST_IDLE;
      state_en  = 1'b0;
      load_en   = 1'b0;
      rdata_en  = 1'b0;
      rd_err_in = 1'b0;
      case (state)
         ST_IDLE: begin
            state_nxt = hwrite ? ST_WR : ST_RD;
            state_en  = accept;
         end
         ST_WR: begin
            // back-to-back transfers go straight to the next data phase
            if (hresp | ~accept) begin
               state_nxt = ST_IDLE;
            end else begin
               state_nxt = hwrite ? ST_WR : ST_RD;
            end
            state_en = ~cmd.full | hresp;
            load_en  = ~cmd.full & ~hresp;
         end
         ST_RD: begin
            state_nxt = hresp ? ST_IDLE : ST_PEND;
            state_en  = ~cmd.full | hresp;
            load_en   = ~cmd.full & ~hresp;
         end
         ST_PEND: begin
            state_nxt = ST_IDLE;
            state_en  = rvalid & ~cmd.issued_write; // response belongs to our read
            rdata_en  = state_en;
            rd_err_in = state_en & (rresp != OKAY);
         end
         default: begin
            state_nxt = ST_IDLE;
            state_en  = 1'b1;
         end
      endcase
   end

   always_ff @(posedge ahb_clk) begin
      if (!rst_n) begin
         state    <= ST_IDLE;
         hresp_q  <= `BRIDGE_HRESP_RST;
         hready_q <= `BRIDGE_HREADY_RST;
         rd_err_q <= `BRIDGE_HRESP_RST;
      end else begin
         if (state_en) begin
            state <= state_nxt;
         end
         hresp_q  <= hresp;
         hready_q <= hready;
         rd_err_q <= rd_err_in;  // one cycle, second cycle comes from hresp_q
      end
   end

   always_ff @(posedge ahb_clk) begin
      if (rdata_en) begin
         rdata_q <= rdata;
      end
   end

   assign misaligned = ((hsize_q == HALF) & haddr_q[0]) |
                       ((hsize_q == WORD) & (|haddr_q[1:0]));

   // byte lanes for the 32-bit data path
   always_comb begin
      case (hsize_q)
         BYTE:    strb = axi_strb_t'(4'b0001 << haddr_q[1:0]);
         HALF:    strb = haddr_q[1] ? 4'b1100 : 4'b0011;
         default: strb = 4'b1111;  // word
      endcase
   end

   assign hresp = ((state != ST_IDLE) & misaligned) |
                  rd_err_q |
                  (hresp_q & ~hready_q);  // second error cycle

   assign hreadyout = hresp ? (hresp_q & ~hready_q) :
                      ((~cmd.full | (state == ST_IDLE)) &
                       (state != ST_RD) & (state != ST_PEND));

   assign hrdata = rdata_q;

   assign cmd.load  = load_en;
   assign cmd.write = hwrite_q;
   assign cmd.addr  = haddr_q;
   assign cmd.size  = hsize_q;
   assign cmd.wdata = hwdata;     // write data is live in the data phase
   assign cmd.strb  = strb;

endmodule

/* axi_cmd_buffer.sv */
`timescale 1ns/1ps

`include "bridge_settings.svh"

module axi_cmd_buffer (
   input  logic               ahb_clk,
   input  logic               rst_n,
   bridge_cmd_if.buffer       cmd,
   output logic               awvalid,
   input  logic               awready,
   output ahb_pkg::haddr_t    awaddr,
   output axi_pkg::axi_size_t awsize,
   output logic               wvalid,
   input  logic               wready,
   output ahb_pkg::hdata_t    wdata,
   output axi_pkg::axi_strb_t wstrb,
   output logic               arvalid,
   input  logic               arready,
   output ahb_pkg::haddr_t    araddr,
   output axi_pkg::axi_size_t arsize
);
   import ahb_pkg::*;
   import axi_pkg::*;

   logic      vld;         // entry held
   logic      write_q;
   haddr_t    addr_q;
   hsize_t    size_q;
   hdata_t    wdata_q;
   axi_strb_t strb_q;

   logic      aw_done;     // AW already taken for this entry
   logic      w_done;      // W already taken for this entry

   logic      aw_hs;
   logic      w_hs;
   logic      ar_hs;
   logic      wr_complete;
   logic      rd_complete;
   logic      complete;

   assign aw_hs = awvalid & awready;
   assign w_hs  = wvalid & wready;
   assign ar_hs = arvalid & arready;

   // a write finishes once both channels have handshaken, in any order
   assign wr_complete = vld & write_q & (aw_done | aw_hs) & (w_done | w_hs);
   assign rd_complete = vld & ~write_q & ar_hs;
   assign complete    = wr_complete | rd_complete;

   always_ff @(posedge ahb_clk) begin
      if (!rst_n) begin
         vld     <= `BRIDGE_VALID_RST;
         write_q <= 1'b0;
         aw_done <= `BRIDGE_VALID_RST;
         w_done  <= `BRIDGE_VALID_RST;
      end else begin
         if (cmd.load) begin
            vld     <= 1'b1;       // new entry replaces a completing one
            write_q <= cmd.write;
         end else if (complete) begin
            vld     <= 1'b0;       // direction kept for issued_write
         end
         if (cmd.load | complete) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
         end else begin
            aw_done <= aw_done | aw_hs;
            w_done  <= w_done | w_hs;
         end
      end
   end

   always_ff @(posedge ahb_clk) begin
      if (cmd.load) begin
         addr_q  <= cmd.addr;
         size_q  <= cmd.size;
         wdata_q <= cmd.wdata;
         strb_q  <= cmd.strb;
      end
   end

   assign cmd.full         = vld & ~complete;
   assign cmd.issued_write = write_q;

   assign awvalid = vld & write_q & ~aw_done;
   assign awaddr  = addr_q;
   assign awsize  = axi_size_t'(size_q);

   assign wvalid  = vld & write_q & ~w_done;
   assign wdata   = wdata_q;
   assign wstrb   = strb_q;

   assign arvalid = vld & ~write_q;
   assign araddr  = addr_q;
   assign arsize  = axi_size_t'(size_q);

endmodule

/* ahb_to_axi4.sv */
`timescale 1ns/1ps

module ahb_to_axi4 (
   input  logic               ahb_clk,
   input  logic               rst_n,

   // AHB-Lite slave
   input  logic               hsel,
   input  ahb_pkg::haddr_t    haddr,
   input  ahb_pkg::htrans_t   htrans,
   input  ahb_pkg::hsize_t    hsize,
   input  logic               hwrite,
   input  ahb_pkg::hdata_t    hwdata,
   input  logic               hreadyin,
   output ahb_pkg::hdata_t    hrdata,
   output logic               hreadyout,
   output logic               hresp,

   // AXI4 master, single beat only
   output logic               awvalid,
   input  logic               awready,
   output ahb_pkg::haddr_t    awaddr,
   output axi_pkg::axi_size_t awsize,
   output logic               wvalid,
   input  logic               wready,
   output ahb_pkg::hdata_t    wdata,
   output axi_pkg::axi_strb_t wstrb,
   output logic               arvalid,
   input  logic               arready,
   output ahb_pkg::haddr_t    araddr,
   output axi_pkg::axi_size_t arsize,
   input  logic               rvalid,    // always accepted
   input  ahb_pkg::hdata_t    rdata,
   input  axi_pkg::axi_resp_t rresp
);

   bridge_cmd_if cmd_bus ();

   ahb_slave_ctrl ctrl0 (
      .ahb_clk   (ahb_clk),
      .rst_n     (rst_n),
      .hsel      (hsel),
      .haddr     (haddr),
      .htrans    (htrans),
      .hsize     (hsize),
      .hwrite    (hwrite),
      .hwdata    (hwdata),
      .hreadyin  (hreadyin),
      .rvalid    (rvalid),
      .rdata     (rdata),
      .rresp     (rresp),
      .hrdata    (hrdata),
      .hreadyout (hreadyout),
      .hresp     (hresp),
      .cmd       (cmd_bus.ctrl)
   );

   axi_cmd_buffer cmdbuf0 (
      .ahb_clk (ahb_clk),
      .rst_n   (rst_n),
      .cmd     (cmd_bus.buffer),
      .awvalid (awvalid),
      .awready (awready),
      .awaddr  (awaddr),
      .awsize  (awsize),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .arsize  (arsize)
   );

endmodule

/* ahb_to_axi4_properties.sv */
`timescale 1ns/1ps

module ahb_to_axi4_properties (
   input logic ahb_clk,
   input logic rst_n,
   input logic hreadyout,
   input logic hresp,
   input logic awvalid,
   input logic awready,
   input logic wvalid,
   input logic wready,
   input logic arvalid,
   input logic arready
);

   int unsigned failures = 0;  // failed assertion count

   // second error cycle follows a stalled first one
   err_two_cycle: assert property (@(posedge ahb_clk) disable iff (!rst_n)
      hresp && hreadyout |-> $past(hresp && !hreadyout))
      else begin
         failures++;
         $error("error response completed without a stalled first cycle");
      end

   aw_hold: assert property (@(posedge ahb_clk) disable iff (!rst_n)
      awvalid && !awready |=> awvalid)
      else begin
         failures++;
         $error("awvalid dropped before awready");
      end

   w_hold: assert property (@(posedge ahb_clk) disable iff (!rst_n)
      wvalid && !wready |=> wvalid)
      else begin
         failures++;
         $error("wvalid dropped before wready");
      end

   ar_hold: assert property (@(posedge ahb_clk) disable iff (!rst_n)
      arvalid && !arready |=> arvalid)
      else begin
         failures++;
         $error("arvalid dropped before arready");
      end

   ready_after_reset: assert property (@(posedge ahb_clk)
      $rose(rst_n) |-> hreadyout)
      else begin
         failures++;
         $error("hreadyout low in the first cycle after reset");
      end

endmodule

/* tb_ahb_to_axi4.sv */
`timescale 1ns/1ps

module tb_ahb_to_axi4;
   import ahb_pkg::*;
   import axi_pkg::*;

   localparam int CLK_PERIOD      = 40;
   localparam int NUM_TESTS       = 6;
   localparam int CYCLES_PER_TEST = 200;
   localparam int WAIT_LIMIT      = 100;  // cycles before a handshake counts as lost

   logic      ahb_clk = 1'b0;
   logic      rst_n;
   logic      hsel;
   haddr_t    haddr;
   htrans_t   htrans;
   hsize_t    hsize;
   logic      hwrite;
   hdata_t    hwdata;
   logic      hreadyin;
   hdata_t    hrdata;
   logic      hreadyout;
   logic      hresp;
   logic      awvalid;
   logic      awready = 1'b0;
   haddr_t    awaddr;
   axi_size_t awsize;
   logic      wvalid;
   logic      wready = 1'b0;
   hdata_t    wdata;
   axi_strb_t wstrb;
   logic      arvalid;
   logic      arready = 1'b0;
   haddr_t    araddr;
   axi_size_t arsize;
   logic      rvalid = 1'b0;
   hdata_t    rdata = '0;
   axi_resp_t rresp = OKAY;

   hdata_t    mem [haddr_t];          // slave memory, word addressed
   haddr_t    aw_addr_log[$];
   axi_size_t aw_size_log[$];
   hdata_t    w_data_log[$];
   axi_strb_t w_strb_log[$];
   haddr_t    ar_addr_log[$];
   axi_size_t ar_size_log[$];
   int        applied = 0;            // AW/W pairs already written to mem
   int        rd_wait = 0;
   logic      rd_pending = 1'b0;
   haddr_t    rd_addr;
   int        ready_odds = 2;         // ready when a draw modulo this is zero
   logic      answer_slverr = 1'b0;

   int unsigned rand_state = 59;
   int          value_errors = 0;
   int          protocol_errors = 0;

   ahb_to_axi4 dut0 (.*);

   bind ahb_to_axi4 ahb_to_axi4_properties props0 (.*);

   always #(CLK_PERIOD/2) ahb_clk = ~ahb_clk;

   function automatic int unsigned next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state >> 16;  // low bits of this generator repeat quickly
   endfunction

   // a full 32-bit word from two draws
   function automatic hdata_t rand_word();
      return {16'(next_rand()), 16'(next_rand())};
   endfunction

   // contents of a word that was never written
   function automatic hdata_t fill_word(input haddr_t a);
      return {a[15:0], a[31:16]} ^ 32'h5ac3_96e1;
   endfunction

   function automatic hdata_t load_word(input haddr_t a);
      haddr_t key;
      key = {a[31:2], 2'b00};
      return mem.exists(key) ? mem[key] : fill_word(key);
   endfunction

   task automatic store_word(input haddr_t a, input hdata_t d, input axi_strb_t strb);
      haddr_t key;
      hdata_t cur;
      key = {a[31:2], 2'b00};
      cur = load_word(key);
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            cur[8*b +: 8] = d[8*b +: 8];
         end
      end
      mem[key] = cur;
   endtask

   // AXI slave with random ready and read latency
   always @(posedge ahb_clk) begin
      if (!rst_n) begin
         awready    <= 1'b0;
         wready     <= 1'b0;
         arready    <= 1'b0;
         rvalid     <= 1'b0;
         rd_pending = 1'b0;
      end else begin
         if (awvalid && awready) begin
            aw_addr_log.push_back(awaddr);
            aw_size_log.push_back(awsize);
         end
         if (wvalid && wready) begin
            w_data_log.push_back(wdata);
            w_strb_log.push_back(wstrb);
         end
         while (applied < aw_addr_log.size() && applied < w_data_log.size()) begin
            store_word(aw_addr_log[applied], w_data_log[applied], w_strb_log[applied]);
            applied++;
         end
         if (arvalid && arready) begin
            ar_addr_log.push_back(araddr);
            ar_size_log.push_back(arsize);
            rd_addr    = araddr;
            rd_wait    = next_rand() % 4;
            rd_pending = 1'b1;
         end
         rvalid <= 1'b0;
         if (rd_pending) begin
            if (rd_wait == 0) begin
               rvalid     <= 1'b1;
               rdata      <= load_word(rd_addr);
               rresp      <= answer_slverr ? SLVERR : OKAY;
               rd_pending = 1'b0;
            end else begin
               rd_wait--;
            end
         end
         awready <= (next_rand() % ready_odds) == 0;
         wready  <= (next_rand() % ready_odds) == 0;
         arready <= (next_rand() % ready_odds) == 0;
      end
   end

   task automatic check_data(input string name, input hdata_t exp, input hdata_t act);
      if (act !== exp) begin
         value_errors++;
         $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input haddr_t exp, input haddr_t act);
      if (act !== exp) begin
         value_errors++;
         $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_strb(input string name, input axi_strb_t exp, input axi_strb_t act);
      if (act !== exp) begin
         value_errors++;
         $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   task automatic check_size(input string name, input axi_size_t exp, input axi_size_t act);
      if (act !== exp) begin
         value_errors++;
         $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      end
   endtask

   task automatic check_resp(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         value_errors++;
         $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   // one AHB transfer, address phase then data phase, no pipelining
   task automatic run_transfer(input logic wr, input haddr_t a, input hsize_t s,
                               input hdata_t d, output hdata_t rd,
                               output logic resp_wait, output logic resp_last);
      int cycles;
      cycles    = 0;
      resp_wait = 1'b0;
      @(posedge ahb_clk);
      hsel   <= 1'b1;
      htrans <= NONSEQ;
      haddr  <= a;
      hsize  <= s;
      hwrite <= wr;
      @(negedge ahb_clk);
      while (!hreadyout) @(negedge ahb_clk);
      @(posedge ahb_clk);
      hsel   <= 1'b0;
      htrans <= IDLE;
      if (wr) begin
         hwdata <= d;
      end
      @(negedge ahb_clk);
      while (!hreadyout && cycles < WAIT_LIMIT) begin
         if (hresp) begin
            resp_wait = 1'b1;  // first error cycle
         end
         cycles++;
         @(negedge ahb_clk);
      end
      if (!hreadyout) begin
         protocol_errors++;
         $display("data phase at address %h never ended, hreadyout stayed low", a);
      end
      resp_last = hresp;
      rd        = hrdata;
      @(posedge ahb_clk);
   endtask

   task automatic ahb_write(input haddr_t a, input hsize_t s, input hdata_t d,
                            output logic resp_wait, output logic resp_last);
      hdata_t unused;
      run_transfer(1'b1, a, s, d, unused, resp_wait, resp_last);
   endtask

   task automatic ahb_read(input haddr_t a, input hsize_t s, output hdata_t rd,
                           output logic resp_wait, output logic resp_last);
      run_transfer(1'b0, a, s, '0, rd, resp_wait, resp_last);
   endtask

   task automatic post_write(input haddr_t a, input hsize_t s, input hdata_t d);
      logic rw;
      logic rl;
      ahb_write(a, s, d, rw, rl);
      check_resp("hresp", 1'b0, rw | rl);
   endtask

   task automatic expect_error_response(input logic rw, input logic rl);
      check_resp("hresp in stalled error cycle", 1'b1, rw);
      check_resp("hresp in final error cycle", 1'b1, rl);
   endtask

   task automatic wait_writes(input int n);
      int cycles;
      cycles = 0;
      while ((aw_addr_log.size() < n || w_data_log.size() < n) && cycles < WAIT_LIMIT) begin
         @(negedge ahb_clk);
         cycles++;
      end
      if (aw_addr_log.size() < n || w_data_log.size() < n) begin
         protocol_errors++;
         $display("AXI write number %0d never completed its AW and W handshakes", n);
      end
   endtask

   task automatic check_write_log(input int idx, input haddr_t a, input hsize_t s,
                                  input hdata_t d, input axi_strb_t strb);
      if (idx < aw_addr_log.size() && idx < w_data_log.size()) begin
         check_addr("awaddr", a, aw_addr_log[idx]);
         check_size("awsize", axi_size_t'(s), aw_size_log[idx]);  // same log2 coding
         check_data("wdata", d, w_data_log[idx]);
         check_strb("wstrb", strb, w_strb_log[idx]);
      end
   endtask

   task automatic write_aligned_word();
      int n;
      n = aw_addr_log.size();
      post_write(32'h0000_0040, WORD, 32'hcafe_f00d);
      wait_writes(n + 1);
      check_write_log(n, 32'h0000_0040, WORD, 32'hcafe_f00d, 4'b1111);
   endtask

   task automatic write_narrow_lanes();
      int        n;
      haddr_t    a;
      hdata_t    d;
      axi_strb_t lane [4];
      lane = '{4'b0001, 4'b0010, 4'b0100, 4'b1000};  // byte lane for each offset
      for (int off = 0; off < 4; off++) begin
         n = aw_addr_log.size();
         a = 32'h0000_0100 + off;
         d = rand_word();
         post_write(a, BYTE, d);
         wait_writes(n + 1);
         check_write_log(n, a, BYTE, d, lane[off]);
      end
      for (int off = 0; off < 4; off += 2) begin
         n = aw_addr_log.size();
         a = 32'h0000_0110 + off;
         d = rand_word();
         post_write(a, HALF, d);
         wait_writes(n + 1);
         check_write_log(n, a, HALF, d, (off == 2) ? 4'b1100 : 4'b0011);
      end
   endtask

   task automatic read_with_latency();
      int     n;
      haddr_t a;
      hdata_t d;
      hdata_t rd;
      logic   rw;
      logic   rl;
      for (int i = 0; i < 4; i++) begin
         a = 32'h0000_1000 + 32'h44 * i;
         ahb_read(a, WORD, rd, rw, rl);
         check_resp("hresp", 1'b0, rw | rl);
         check_data("hrdata", fill_word(a), rd);
         if (ar_addr_log.size() > 0) begin
            check_addr("araddr", a, ar_addr_log[$]);
            check_size("arsize", 3'd2, ar_size_log[$]);  // four bytes per beat
         end else begin
            protocol_errors++;
            $display("read at address %h completed without an AR handshake", a);
         end
      end
      n = aw_addr_log.size();
      d = rand_word();
      post_write(32'h0000_2000, WORD, d);
      wait_writes(n + 1);
      ahb_read(32'h0000_2000, WORD, rd, rw, rl);
      check_resp("hresp", 1'b0, rw | rl);
      check_data("hrdata", d, rd);  // written word comes back
   endtask

   task automatic reject_unaligned();
      int     n_aw;
      int     n_w;
      int     n_ar;
      hdata_t rd;
      logic   rw;
      logic   rl;
      n_aw = aw_addr_log.size();
      n_w  = w_data_log.size();
      n_ar = ar_addr_log.size();
      ahb_write(32'h0000_0201, HALF, 32'h1111_2222, rw, rl);
      expect_error_response(rw, rl);
      ahb_write(32'h0000_0202, WORD, 32'h3333_4444, rw, rl);
      expect_error_response(rw, rl);
      ahb_read(32'h0000_0203, HALF, rd, rw, rl);
      expect_error_response(rw, rl);
      ahb_read(32'h0000_0201, WORD, rd, rw, rl);
      expect_error_response(rw, rl);
      repeat (10) @(posedge ahb_clk);
      if (aw_addr_log.size() != n_aw || w_data_log.size() != n_w ||
          ar_addr_log.size() != n_ar) begin
         protocol_errors++;
         $display("an unaligned access reached the AXI bus");
      end
   endtask

   task automatic read_slave_error();
      hdata_t rd;
      logic   rw;
      logic   rl;
      answer_slverr = 1'b1;
      ahb_read(32'h0000_0500, WORD, rd, rw, rl);
      answer_slverr = 1'b0;
      expect_error_response(rw, rl);
   endtask

   task automatic write_under_backpressure();
      haddr_t    ea [6];
      hsize_t    es [6];
      hdata_t    ed [6];
      axi_strb_t eb [6];
      int        n;
      n          = aw_addr_log.size();
      ready_odds = 4;  // slow AW and W
      for (int i = 0; i < 6; i++) begin
         ea[i] = 32'h0000_3000 + 4 * i;
         es[i] = WORD;
         eb[i] = 4'b1111;
         ed[i] = rand_word();
         if (i == 2) begin
            ea[i] = ea[i] + 2;
            es[i] = HALF;
            eb[i] = 4'b1100;
         end else if (i == 4) begin
            ea[i] = ea[i] + 1;
            es[i] = BYTE;
            eb[i] = 4'b0010;
         end
         post_write(ea[i], es[i], ed[i]);
      end
      wait_writes(n + 6);
      ready_odds = 2;
      repeat (10) @(posedge ahb_clk);
      for (int i = 0; i < 6; i++) begin
         check_write_log(n + i, ea[i], es[i], ed[i], eb[i]);
      end
      if (aw_addr_log.size() != n + 6 || w_data_log.size() != n + 6) begin
         protocol_errors++;
         $display("AXI saw %0d AW and %0d W handshakes, expected %0d of each",
                  aw_addr_log.size() - n, w_data_log.size() - n, 6);
      end
   endtask

   initial begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, tests did not finish",
               NUM_TESTS * CYCLES_PER_TEST);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      rst_n    = 1'b0;
      hsel     = 1'b0;
      haddr    = '0;
      htrans   = IDLE;
      hsize    = WORD;
      hwrite   = 1'b0;
      hwdata   = '0;
      hreadyin = 1'b1;  // single slave, bus ready follows hreadyout
      repeat (5) @(posedge ahb_clk);
      rst_n <= 1'b1;
      @(negedge ahb_clk);
      check_resp("hreadyout", 1'b1, hreadyout);
      check_resp("hresp", 1'b0, hresp);
      check_resp("awvalid", 1'b0, awvalid);
      check_resp("wvalid", 1'b0, wvalid);
      check_resp("arvalid", 1'b0, arvalid);

      write_aligned_word();
      write_narrow_lanes();
      read_with_latency();
      reject_unaligned();
      read_slave_error();
      write_under_backpressure();

      repeat (5) @(posedge ahb_clk);
      $display("errors: %0d value mismatches, %0d protocol failures, %0d assertion failures",
               value_errors, protocol_errors, dut0.props0.failures);
      if (value_errors == 0 && protocol_errors == 0 && dut0.props0.failures == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* tb.f */
+incdir+.
ahb_pkg.sv
axi_pkg.sv
bridge_cmd_if.sv
ahb_slave_ctrl.sv
axi_cmd_buffer.sv
ahb_to_axi4.sv
ahb_to_axi4_properties.sv
tb_ahb_to_axi4.sv
